// ==== compile.f ====
+incdir+testbench
src/rv_isa_pkg.sv
src/bpu_pkg.sv
src/bpu_predecode.sv
src/bpu_direction.sv
src/bpu_btb.sv
src/bpu_ras.sv
src/bpu_target_select.sv
src/bpu_top.sv
testbench/bpu_tb.sv

// ==== src/bpu_btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_btb #(
    parameter int unsigned BTB_ENTRIES = 256
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [bpu_pkg::XLEN-1:0]  fetch_pc_i,
    input  bpu_pkg::resolve_t         resolve_i,
    output logic                      hit_o,
    output logic [bpu_pkg::XLEN-1:0]  target_o
);
    import bpu_pkg::*;

    localparam int IDX_W    = $clog2(BTB_ENTRIES);
    localparam int TAG_BITS = XLEN - IDX_W - 2; // everything above the index

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [XLEN-1:0]     target;
    } btb_entry_t;

    btb_entry_t             tbl [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] vld_q;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    btb_entry_t       rd_entry;
    logic             wr_en;

    assign rd_idx   = fetch_pc_i[IDX_W+1:2];
    assign rd_entry = tbl[rd_idx];
    assign hit_o    = vld_q[rd_idx] && (rd_entry.tag == fetch_pc_i[XLEN-1:IDX_W+2]);
    assign target_o = rd_entry.target;

    assign wr_idx = resolve_i.pc[IDX_W+1:2];
    assign wr_en  = resolve_i.valid && resolve_i.taken; // any taken transfer

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tbl[wr_idx] <= '{tag: resolve_i.pc[XLEN-1:IDX_W+2], target: resolve_i.target};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else if (wr_en) begin
            vld_q[wr_idx] <= 1'b1;
        end
    end

    // execute must hand back a halfword aligned target
    a_target_align: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !resolve_i.target[0]);

endmodule

`default_nettype wire

// ==== src/bpu_direction.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_direction #(
    parameter int unsigned BIMODAL_ENTRIES = 512,
    parameter int unsigned TAGGED_ENTRIES  = 256
) (
    input  logic                           clk,
    input  logic                           rst,
    input  bpu_pkg::fetch_t                fetch_i,
    input  bpu_pkg::resolve_t              resolve_i,
    output logic                           taken_o,
    output bpu_pkg::provider_e             provider_o,
    output logic [bpu_pkg::HIST_LEN-1:0]   history_o
);
    import bpu_pkg::*;

    localparam int BM_W = $clog2(BIMODAL_ENTRIES);
    localparam int TG_W = $clog2(TAGGED_ENTRIES);

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        ctr_t             ctr;
    } tag_entry_t;

    typedef struct packed {
        logic [BM_W-1:0]  bm_idx;
        logic [TG_W-1:0]  short_idx;
        logic [TG_W-1:0]  long_idx;
        logic [TAG_W-1:0] short_tag;
        logic [TAG_W-1:0] long_tag;
    } lookup_t;

    // short half uses the low byte, long half the high byte
    function automatic lookup_t hash(input logic [XLEN-1:0] pc,
                                     input logic [HIST_LEN-1:0] hist);
        lookup_t l;
        l.bm_idx    = pc[BM_W+1:2];
        l.short_idx = pc[TG_W+1:2] ^ TG_W'(hist[7:0]);
        l.long_idx  = pc[TG_W+1:2] ^ TG_W'(hist[HIST_LEN-1 -: 8]);
        l.short_tag = pc[8 +: TAG_W] ^ hist[TAG_W-1:0];
        l.long_tag  = pc[8 +: TAG_W] ^ hist[HIST_LEN-1 -: TAG_W];
        return l;
    endfunction

    ctr_t                   bm_tbl [BIMODAL_ENTRIES];
    tag_entry_t             short_tbl [TAGGED_ENTRIES];
    tag_entry_t             long_tbl [TAGGED_ENTRIES];
    logic [TAGGED_ENTRIES-1:0] short_vld;
    logic [TAGGED_ENTRIES-1:0] long_vld;
    logic [HIST_LEN-1:0]    hist_q;

    lookup_t    fl;
    lookup_t    rl;
    tag_entry_t short_rd;
    tag_entry_t long_rd;
    logic       short_hit;
    logic       long_hit;

    assign fl       = hash(fetch_i.pc, hist_q);
    assign rl       = hash(resolve_i.pc, resolve_i.hist_snap);
    assign short_rd = short_tbl[fl.short_idx];
    assign long_rd  = long_tbl[fl.long_idx];
    assign short_hit = short_vld[fl.short_idx] && (short_rd.tag == fl.short_tag);
    assign long_hit  = long_vld[fl.long_idx] && (long_rd.tag == fl.long_tag);

    always_comb begin
        if (long_hit) begin
            provider_o = PROV_LONG;
            taken_o    = long_rd.ctr[1];
        end else if (short_hit) begin
            provider_o = PROV_SHORT;
            taken_o    = short_rd.ctr[1];
        end else begin
            provider_o = PROV_BASE;
            taken_o    = bm_tbl[fl.bm_idx][1];
        end
    end

    assign history_o = hist_q;

    logic br_upd;      // tagged tables only learn from branches
    logic long_match;  // long entry already there at resolve index
    logic alloc_long;
    logic alloc_short;
    ctr_t weak_ctr;
    ctr_t strong_ctr;

    assign br_upd     = resolve_i.valid && (resolve_i.kind == KIND_BRANCH);
    assign long_match = long_vld[rl.long_idx] && (long_tbl[rl.long_idx].tag == rl.long_tag);
    assign alloc_long  = br_upd && resolve_i.mispredict &&
                         (resolve_i.provider == PROV_BASE) && !long_match;
    assign alloc_short = br_upd && resolve_i.mispredict &&
                         (resolve_i.provider == PROV_BASE) && long_match;
    assign weak_ctr   = resolve_i.taken ? CTR_WEAK_T : CTR_WEAK_NT;
    assign strong_ctr = resolve_i.taken ? CTR_STRONG_T : CTR_STRONG_NT;

    always_ff @(posedge clk) begin
        if (br_upd && resolve_i.provider == PROV_LONG) begin
            long_tbl[rl.long_idx].ctr <= resolve_i.mispredict ? strong_ctr :
                ctr_step(long_tbl[rl.long_idx].ctr, resolve_i.taken);
        end
        if (br_upd && resolve_i.provider == PROV_SHORT) begin
            short_tbl[rl.short_idx].ctr <= resolve_i.mispredict ? strong_ctr :
                ctr_step(short_tbl[rl.short_idx].ctr, resolve_i.taken);
        end
        if (alloc_long) begin
            long_tbl[rl.long_idx] <= '{tag: rl.long_tag, ctr: weak_ctr};
        end
        if (alloc_short) begin
            short_tbl[rl.short_idx] <= '{tag: rl.short_tag, ctr: weak_ctr};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                bm_tbl[i] <= CTR_WEAK_NT;
            end
            short_vld <= '0;
            long_vld  <= '0;
            hist_q    <= '0;
        end else begin
            if (resolve_i.valid) begin
                bm_tbl[rl.bm_idx] <= ctr_step(bm_tbl[rl.bm_idx], resolve_i.taken);
                hist_q <= {hist_q[HIST_LEN-2:0], resolve_i.taken};
            end
            if (alloc_long) begin
                long_vld[rl.long_idx] <= 1'b1;
            end
            if (alloc_short) begin
                short_vld[rl.short_idx] <= 1'b1;
            end
        end
    end

    // the fourth code would come back from execute and train nothing
    a_provider_code: assert property (@(posedge clk) disable iff (rst)
        resolve_i.valid |-> resolve_i.provider != 2'd3);

endmodule

`default_nettype wire

// ==== src/bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    localparam int XLEN     = 32;
    localparam int HIST_LEN = 16; // global history bits
    localparam int TAG_W    = 10; // tagged table tag
    localparam int SP_W     = 4;  // ras pointer snapshot

    typedef logic [1:0] ctr_t; // msb set means taken

    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;
    localparam ctr_t CTR_WEAK_T    = 2'b10;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    typedef enum logic [1:0] {
        PROV_BASE  = 2'd0,
        PROV_SHORT = 2'd1,
        PROV_LONG  = 2'd2
    } provider_e;

    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JAL    = 2'd2,
        KIND_JALR   = 2'd3
    } ctrl_kind_e;

    typedef struct packed {
        logic                valid;
        logic [XLEN-1:0]     pc;
        rv_isa_pkg::rv_inst_u inst;
    } fetch_t;

    typedef struct packed {
        logic                is_ctrl;
        ctrl_kind_e          kind;
        logic                is_ret;
        logic                taken;
        logic [XLEN-1:0]     next_pc;
        provider_e           provider;
        logic [HIST_LEN-1:0] hist_snap;
        logic [SP_W-1:0]     ras_sp_snap;
    } pred_t;

    typedef struct packed {
        logic                valid;
        logic [XLEN-1:0]     pc;
        ctrl_kind_e          kind;
        logic                is_ret;
        logic                taken;
        logic                mispredict;
        logic [XLEN-1:0]     target;
        provider_e           provider;
        logic [HIST_LEN-1:0] hist_snap;
        logic [SP_W-1:0]     ras_sp_snap;
    } resolve_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr; // return address from decode
    } push_t;

    typedef struct packed {
        ctrl_kind_e      kind;
        logic            is_ret;
        logic [XLEN-1:0] direct_target;
    } predecode_t;

    // saturating step toward the outcome
    function automatic ctr_t ctr_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        end else begin
            return (c == CTR_STRONG_NT) ? c : c - 2'd1;
        end
    endfunction

endpackage

`default_nettype wire

// ==== src/bpu_predecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_predecode (
    input  bpu_pkg::fetch_t     fetch_i,
    output bpu_pkg::predecode_t dec_o
);
    import rv_isa_pkg::*;
    import bpu_pkg::*;

    rv_inst_u        inst;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;

    assign inst = fetch_i.inst;

    // same word, two immediate layouts
    assign b_imm = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
                    inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
    assign j_imm = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
                    inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

    always_comb begin
        dec_o = '0;
        if (fetch_i.valid) begin
            case (inst.b_fmt.opcode)
                OPC_BRANCH: begin
                    dec_o.kind          = KIND_BRANCH;
                    dec_o.direct_target = fetch_i.pc + b_imm;
                end
                OPC_JAL: begin
                    dec_o.kind          = KIND_JAL;
                    dec_o.direct_target = fetch_i.pc + j_imm;
                end
                OPC_JALR: begin
                    dec_o.kind   = KIND_JALR;
                    dec_o.is_ret = (inst.b_fmt.rs1 == REG_RA); // jalr through ra
                end
                default: dec_o.kind = KIND_NONE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/bpu_ras.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_ras #(
    parameter int unsigned RAS_DEPTH = 8
) (
    input  logic                      clk,
    input  logic                      rst,
    input  bpu_pkg::push_t            push_i,
    input  bpu_pkg::resolve_t         resolve_i,
    output logic                      top_valid_o,
    output logic [bpu_pkg::XLEN-1:0]  top_o,
    output logic [bpu_pkg::SP_W-1:0]  sp_o
);
    import bpu_pkg::*;

    localparam int IDX_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

    logic [XLEN-1:0] stack_q [RAS_DEPTH];
    logic [SP_W-1:0] sp_q;       // next free slot
    logic [SP_W-1:0] sp_restored;
    logic [SP_W-1:0] sp_popped;
    logic            pop_en;
    logic            push_en;

    // restore, then pop, then push
    always_comb begin
        sp_restored = (resolve_i.valid && resolve_i.mispredict) ?
                      resolve_i.ras_sp_snap : sp_q;
        pop_en      = resolve_i.valid && resolve_i.is_ret && resolve_i.taken &&
                      (sp_restored != '0);
        sp_popped   = pop_en ? sp_restored - 1'b1 : sp_restored;
        push_en     = push_i.valid && (sp_popped < SP_W'(RAS_DEPTH)); // full drops
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            stack_q[IDX_W'(sp_popped)] <= push_i.addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else begin
            sp_q <= push_en ? sp_popped + 1'b1 : sp_popped;
        end
    end

    assign top_valid_o = (sp_q != '0);
    assign top_o       = stack_q[IDX_W'(sp_q - 1'b1)]; // junk when empty, gated by valid
    assign sp_o        = sp_q;

    // a bad snapshot from execute would show up here first
    a_sp_range: assert property (@(posedge clk) disable iff (rst)
        sp_q <= SP_W'(RAS_DEPTH));

endmodule

`default_nettype wire

// ==== src/bpu_target_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_target_select (
    input  bpu_pkg::predecode_t           dec_i,
    input  logic [bpu_pkg::XLEN-1:0]      fetch_pc_i,
    input  logic                          dir_taken_i,
    input  bpu_pkg::provider_e            provider_i,
    input  logic [bpu_pkg::HIST_LEN-1:0]  history_i,
    input  logic                          btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0]      btb_target_i,
    input  logic                          ras_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]      ras_top_i,
    input  logic [bpu_pkg::SP_W-1:0]      ras_sp_i,
    output bpu_pkg::pred_t                pred_o
);
    import bpu_pkg::*;

    logic [XLEN-1:0] seq_pc;
    logic            taken;

    assign seq_pc = fetch_pc_i + 32'd4;

    always_comb begin
        case (dec_i.kind)
            KIND_BRANCH: taken = dir_taken_i;
            KIND_JAL:    taken = 1'b1;
            KIND_JALR:   taken = dec_i.is_ret || btb_hit_i; // indirect needs a btb entry
            default:     taken = 1'b0;
        endcase
    end

    always_comb begin
        pred_o             = '0;
        pred_o.is_ctrl     = (dec_i.kind != KIND_NONE);
        pred_o.kind        = dec_i.kind;
        pred_o.is_ret      = dec_i.is_ret;
        pred_o.taken       = taken;
        pred_o.provider    = provider_i;
        pred_o.hist_snap   = history_i;
        pred_o.ras_sp_snap = ras_sp_i;
        if (dec_i.is_ret) begin
            pred_o.next_pc = ras_valid_i ? ras_top_i :
                             btb_hit_i   ? btb_target_i : seq_pc;
        end else if (taken) begin
            pred_o.next_pc = btb_hit_i ? btb_target_i : dec_i.direct_target;
        end else begin
            pred_o.next_pc = seq_pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/bpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_top #(
    parameter int unsigned BIMODAL_ENTRIES = 512,
    parameter int unsigned TAGGED_ENTRIES  = 256,
    parameter int unsigned BTB_ENTRIES     = 256,
    parameter int unsigned RAS_DEPTH       = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  bpu_pkg::fetch_t               fetch_i,
    input  bpu_pkg::resolve_t             resolve_i,
    input  bpu_pkg::push_t                push_i,
    output bpu_pkg::pred_t                pred_o,
    output logic [bpu_pkg::HIST_LEN-1:0]  history_o
);
    import bpu_pkg::*;

    predecode_t      dec;
    logic            dir_taken;
    provider_e       provider;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;
    logic            ras_valid;
    logic [XLEN-1:0] ras_top;
    logic [SP_W-1:0] ras_sp;

    bpu_predecode u_predecode (
        .fetch_i (fetch_i),
        .dec_o   (dec)
    );

    bpu_direction #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES),
        .TAGGED_ENTRIES  (TAGGED_ENTRIES)
    ) u_direction (
        .clk        (clk),
        .rst        (rst),
        .fetch_i    (fetch_i),
        .resolve_i  (resolve_i),
        .taken_o    (dir_taken),
        .provider_o (provider),
        .history_o  (history_o)
    );

    bpu_btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb (
        .clk        (clk),
        .rst        (rst),
        .fetch_pc_i (fetch_i.pc),
        .resolve_i  (resolve_i),
        .hit_o      (btb_hit),
        .target_o   (btb_target)
    );

    bpu_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) u_ras (
        .clk         (clk),
        .rst         (rst),
        .push_i      (push_i),
        .resolve_i   (resolve_i),
        .top_valid_o (ras_valid),
        .top_o       (ras_top),
        .sp_o        (ras_sp)
    );

    bpu_target_select u_target_select (
        .dec_i        (dec),
        .fetch_pc_i   (fetch_i.pc),
        .dir_taken_i  (dir_taken),
        .provider_i   (provider),
        .history_i    (history_o),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_valid_i  (ras_valid),
        .ras_top_i    (ras_top),
        .ras_sp_i     (ras_sp),
        .pred_o       (pred_o)
    );

endmodule

`default_nettype wire

// ==== src/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // major opcodes for control transfers
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [4:0] REG_RA = 5'd1; // x1, link register

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;     // same bits as jalr rs1
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } rv_inst_u;

endpackage

`default_nettype wire

// ==== testbench/bpu_tb_vectors.svh ====
`ifndef BPU_TB_VECTORS_SVH
`define BPU_TB_VECTORS_SVH

// one row per cycle: fetch, resolve, push, expected pred_o, expected history_o
// make_pred takes kind, is_ret, taken, next_pc, provider, stack pointer
task automatic load_vectors();
    // 0..1 straight after reset
    add_row(make_fetch(1'b1, 32'h1000, NOP_WORD), NO_RES, NO_PUSH,
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1004, PROV_BASE, 4'd0), 16'h0000);
    add_row(make_fetch(1'b1, 32'h1100, enc_branch(13'h040)), NO_RES, NO_PUSH,
            make_pred(KIND_BRANCH, 1'b0, 1'b0, 32'h1104, PROV_BASE, 4'd0), 16'h0000);
    // 2..3 jal direct target, then btb target after taken resolve
    add_row(make_fetch(1'b1, 32'h1200, enc_jal(21'h00080)),
            make_resolve(32'h1200, KIND_JAL, 1'b0, 1'b1, 1'b1, 32'h1300, PROV_BASE, 16'h0, 4'd0),
            NO_PUSH,
            make_pred(KIND_JAL, 1'b0, 1'b1, 32'h1280, PROV_BASE, 4'd0), 16'h0000);
    add_row(make_fetch(1'b1, 32'h1200, enc_jal(21'h00080)), NO_RES, NO_PUSH,
            make_pred(KIND_JAL, 1'b0, 1'b1, 32'h1300, PROV_BASE, 4'd0), 16'h0001);
    // 4..5 branch mispredicted taken, long entry allocated at snapshot history
    add_row(make_fetch(1'b1, 32'h1400, NOP_WORD),
            make_resolve(32'h1100, KIND_BRANCH, 1'b0, 1'b1, 1'b1, 32'h1140, PROV_BASE, 16'h0, 4'd0),
            NO_PUSH,
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1404, PROV_BASE, 4'd0), 16'h0001);
    add_row(make_fetch(1'b1, 32'h1100, enc_branch(13'h040)), NO_RES, NO_PUSH,
            make_pred(KIND_BRANCH, 1'b0, 1'b1, 32'h1140, PROV_LONG, 4'd0), 16'h0003);
    // 6..10 two calls, returns in lifo order, then empty stack
    add_row(make_fetch(1'b1, 32'h1010, NOP_WORD), NO_RES, make_push(32'h2004),
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1014, PROV_BASE, 4'd0), 16'h0003);
    add_row(make_fetch(1'b1, 32'h1020, NOP_WORD), NO_RES, make_push(32'h3008),
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1024, PROV_BASE, 4'd1), 16'h0003);
    add_row(make_fetch(1'b1, 32'h1030, RET_WORD),
            make_resolve(32'h1030, KIND_JALR, 1'b1, 1'b1, 1'b0, 32'h3008, PROV_BASE, 16'h3, 4'd2),
            NO_PUSH,
            make_pred(KIND_JALR, 1'b1, 1'b1, 32'h3008, PROV_BASE, 4'd2), 16'h0003);
    add_row(make_fetch(1'b1, 32'h1040, RET_WORD),
            make_resolve(32'h1040, KIND_JALR, 1'b1, 1'b1, 1'b0, 32'h2004, PROV_BASE, 16'h7, 4'd1),
            NO_PUSH,
            make_pred(KIND_JALR, 1'b1, 1'b1, 32'h2004, PROV_BASE, 4'd1), 16'h0007);
    add_row(make_fetch(1'b1, 32'h1050, RET_WORD), NO_RES, NO_PUSH,
            make_pred(KIND_JALR, 1'b1, 1'b1, 32'h1054, PROV_BASE, 4'd0), 16'h000f);
    // 11..15 three pushes, mispredict restores depth 1
    add_row(make_fetch(1'b1, 32'h1070, NOP_WORD), NO_RES, make_push(32'h4000),
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1074, PROV_BASE, 4'd0), 16'h000f);
    add_row(make_fetch(1'b1, 32'h1080, NOP_WORD), NO_RES, make_push(32'h5000),
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1084, PROV_BASE, 4'd1), 16'h000f);
    add_row(make_fetch(1'b1, 32'h1090, NOP_WORD), NO_RES, make_push(32'h6000),
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h1094, PROV_BASE, 4'd2), 16'h000f);
    add_row(make_fetch(1'b1, 32'h10a0, NOP_WORD),
            make_resolve(32'h1060, KIND_JAL, 1'b0, 1'b1, 1'b1, 32'h1400, PROV_BASE, 16'hf, 4'd1),
            NO_PUSH,
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h10a4, PROV_BASE, 4'd3), 16'h000f);
    add_row(make_fetch(1'b1, 32'h10b0, RET_WORD), NO_RES, NO_PUSH,
            make_pred(KIND_JALR, 1'b1, 1'b1, 32'h4000, PROV_BASE, 4'd1), 16'h001f);
    // 16..17 not-taken resolve shifts in a zero, counter goes strong not-taken
    add_row(make_fetch(1'b1, 32'h10c0, NOP_WORD),
            make_resolve(32'h10d0, KIND_BRANCH, 1'b0, 1'b0, 1'b0, 32'h10d4, PROV_BASE, 16'h1f, 4'd1),
            NO_PUSH,
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h10c4, PROV_BASE, 4'd1), 16'h001f);
    add_row(make_fetch(1'b1, 32'h10d0, enc_branch(13'h020)), NO_RES, NO_PUSH,
            make_pred(KIND_BRANCH, 1'b0, 1'b0, 32'h10d4, PROV_BASE, 4'd1), 16'h003e);
    // 18 idle slot holding a jal word
    add_row(make_fetch(1'b0, 32'h10e0, enc_jal(21'h00100)), NO_RES, NO_PUSH,
            make_pred(KIND_NONE, 1'b0, 1'b0, 32'h10e4, PROV_BASE, 4'd1), 16'h003e);
endtask

`endif

// ==== testbench/bpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;
    import bpu_pkg::*;
    import rv_isa_pkg::*;

    localparam int HALF       = 10;
    localparam int RST_CYCLES = 8;
    localparam int WAIT_LIMIT = 50;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [31:0] RET_WORD = 32'h0000_8067; // jalr x0, 0(ra)
    localparam resolve_t    NO_RES   = '0;
    localparam push_t       NO_PUSH  = '0;

    typedef struct packed {
        fetch_t              fetch;
        resolve_t            resolve;
        push_t               push;
        pred_t               exp_pred;
        logic [HIST_LEN-1:0] exp_hist;
    } vec_t;

    logic                clk;
    logic                rst;
    fetch_t              fetch;
    resolve_t            resolve;
    push_t               push;
    pred_t               pred;
    logic [HIST_LEN-1:0] history;

    vec_t vectors[$];

    bpu_top #(
        .BIMODAL_ENTRIES (512),
        .TAGGED_ENTRIES  (256),
        .BTB_ENTRIES     (256),
        .RAS_DEPTH       (8)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .fetch_i   (fetch),
        .resolve_i (resolve),
        .push_i    (push),
        .pred_o    (pred),
        .history_o (history)
    );

    // beq x0, x0 with a 13-bit offset
    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    // jal x0 with a 21-bit offset
    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, OPC_JAL};
    endfunction

    function automatic fetch_t make_fetch(input logic vld, input logic [31:0] pc,
                                          input logic [31:0] word);
        fetch_t f;
        f.valid = vld;
        f.pc    = pc;
        f.inst  = word;
        return f;
    endfunction

    function automatic resolve_t make_resolve(input logic [31:0] pc, input ctrl_kind_e kind,
                                              input logic is_ret, input logic taken,
                                              input logic mis, input logic [31:0] target,
                                              input provider_e prov,
                                              input logic [HIST_LEN-1:0] hist,
                                              input logic [SP_W-1:0] sp);
        resolve_t r;
        r = '{valid: 1'b1, pc: pc, kind: kind, is_ret: is_ret, taken: taken,
              mispredict: mis, target: target, provider: prov, hist_snap: hist,
              ras_sp_snap: sp};
        return r;
    endfunction

    function automatic push_t make_push(input logic [31:0] addr);
        push_t p;
        p.valid = 1'b1;
        p.addr  = addr;
        return p;
    endfunction

    // hist_snap is filled in by add_row
    function automatic pred_t make_pred(input ctrl_kind_e kind, input logic is_ret,
                                        input logic taken, input logic [31:0] next_pc,
                                        input provider_e prov, input logic [SP_W-1:0] sp);
        pred_t p;
        p = '0;
        p.is_ctrl     = (kind != KIND_NONE);
        p.kind        = kind;
        p.is_ret      = is_ret;
        p.taken       = taken;
        p.next_pc     = next_pc;
        p.provider    = prov;
        p.ras_sp_snap = sp;
        return p;
    endfunction

    function automatic void add_row(input fetch_t f, input resolve_t r, input push_t p,
                                    input pred_t e, input logic [HIST_LEN-1:0] hist);
        vec_t v;
        v.fetch              = f;
        v.resolve            = r;
        v.push               = p;
        v.exp_pred           = e;
        v.exp_pred.hist_snap = hist; // snapshot is the live history
        v.exp_hist           = hist;
        vectors.push_back(v);
    endfunction

    `include "bpu_tb_vectors.svh"

    task automatic check_pred(input string name, input pred_t got, input pred_t want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            $display("Some tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_hist(input string name, input logic [HIST_LEN-1:0] got,
                              input logic [HIST_LEN-1:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
            $display("Some tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #HALF clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst <= 1'b0;
    end

    initial begin
        int waited;
        fetch   = '0;
        resolve = '0;
        push    = '0;
        load_vectors();
        for (int row = 0; row < vectors.size(); row++) begin
            @(negedge clk);
            waited = 0;
            while (rst) begin
                if (waited == WAIT_LIMIT) begin
                    $display("reset still asserted after %0d cycles", WAIT_LIMIT);
                    $display("Some tests failed");
                    $fatal(1, "reset timeout");
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
            fetch   = vectors[row].fetch;
            resolve = vectors[row].resolve;
            push    = vectors[row].push;
            #(HALF - 1); // just before the next rising edge
            check_pred($sformatf("pred_o row %0d", row), pred, vectors[row].exp_pred);
            check_hist($sformatf("history_o row %0d", row), history, vectors[row].exp_hist);
        end
        @(negedge clk);
        fetch   = '0;
        resolve = '0;
        push    = '0;
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
